/* hw/daq_bus_pkg.sv */
package daq_bus_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int REG_W = 8;

    // Chip reset pulse length field
    localparam int PULSE_WIDTH_W = 8;

    typedef logic [REG_W-1:0] reg_data_t;

    // One APB request, setup and access phase alike
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [ADDR_W-1:0] paddr;
        reg_data_t pwdata;
    } apb_req_t;

    // Register map
    localparam logic [ADDR_W-1:0] ADDR_VERSION = 32'd0;
    localparam logic [ADDR_W-1:0] ADDR_VER_MINOR = 32'd1;
    localparam logic [ADDR_W-1:0] ADDR_VER_MAJOR = 32'd2;
    localparam logic [ADDR_W-1:0] ADDR_BOARD = 32'd3;
    localparam logic [ADDR_W-1:0] ADDR_CONFIGURED = 32'd4;
    localparam logic [ADDR_W-1:0] ADDR_CONTROL = 32'd16;
    localparam logic [ADDR_W-1:0] ADDR_PULSE_WIDTH = 32'd17;
    localparam logic [ADDR_W-1:0] ADDR_PULSE_START = 32'd18;

    // Register block version, read at ADDR_VERSION
    localparam reg_data_t MODULE_VERSION = 8'd1;

    // Control register bits
    localparam int CTRL_TRIGGER_EN = 0;
    localparam int CTRL_TDC_EN = 1;
    localparam int CTRL_RESET_HOLD = 2;
    localparam int CTRL_W = 3;

    // Settings driven to the data path and the pulser
    typedef struct packed {
        logic trigger_en;
        logic tdc_en;
        logic reset_hold;
        logic [PULSE_WIDTH_W-1:0] pulse_width;
        logic pulse_start;
    } ctrl_t;

endpackage

/* hw/daq_core.sv */
module daq_core #(
    parameter daq_bus_pkg::reg_data_t VERSION_MAJOR = 8'd1,
    parameter daq_bus_pkg::reg_data_t VERSION_MINOR = 8'd2,
    parameter daq_bus_pkg::reg_data_t BOARD_ID = 8'd0,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    BUS_CLK,
    input  logic                    BUS_RST,
    input  daq_bus_pkg::apb_req_t   apb,
    output daq_bus_pkg::reg_data_t  prdata,
    input  logic                    trigger,
    input  logic                    hitor,
    output daq_data_pkg::daq_word_t out_word,
    output logic                    out_write,
    input  logic                    out_ready,
    output logic                    trigger_busy,
    output logic                    chip_reset_n
);

    daq_bus_pkg::ctrl_t ctrl;

    // Source heads and their grants
    daq_data_pkg::src_port_t trig_src;
    daq_data_pkg::src_port_t tdc_src;
    logic trig_grant;
    logic tdc_grant;

    daq_regs #(
        .VERSION_MAJOR(VERSION_MAJOR),
        .VERSION_MINOR(VERSION_MINOR),
        .BOARD_ID(BOARD_ID)
    ) u_regs (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .apb(apb),
        .prdata(prdata),
        .ctrl(ctrl)
    );

    reset_pulser u_rst_pulser (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .pulse_start(ctrl.pulse_start),
        .pulse_width(ctrl.pulse_width),
        .reset_hold(ctrl.reset_hold),
        .chip_reset_n(chip_reset_n)
    );

    trigger_recorder #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_trig (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .trigger(trigger),
        .trigger_en(ctrl.trigger_en),
        .src(trig_src),
        .grant(trig_grant),
        .trigger_busy(trigger_busy)
    );

    hitor_tdc #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tdc (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .hitor(hitor),
        .tdc_en(ctrl.tdc_en),
        .src(tdc_src),
        .grant(tdc_grant)
    );

    rr_arbiter u_arb (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .trig_src(trig_src),
        .tdc_src(tdc_src),
        .trig_grant(trig_grant),
        .tdc_grant(tdc_grant),
        .out_word(out_word),
        .out_write(out_write),
        .out_ready(out_ready)
    );

endmodule

/* hw/daq_data_pkg.sv */
package daq_data_pkg;

    // Word width toward the external FIFO
    localparam int WORD_W = 32;

    // TDC word field widths
    localparam int TDC_ID_W = 4;
    localparam int TDC_HIT_W = 12;
    localparam int TDC_LEN_W = 16;

    typedef logic [WORD_W-1:0] daq_word_t;

    // Trigger word, flag always set
    typedef struct packed {
        logic flag;
        logic [WORD_W-2:0] number;
    } trigger_word_t;

    // TDC word: id, hit number, high time in cycles
    typedef struct packed {
        logic [TDC_ID_W-1:0] id;
        logic [TDC_HIT_W-1:0] hit;
        logic [TDC_LEN_W-1:0] width;
    } tdc_word_t;

    // Identifier in the top nibble of TDC words
    localparam logic [TDC_ID_W-1:0] TDC_ID = 4'd2;

    // Width saturates here
    localparam logic [TDC_LEN_W-1:0] TDC_WIDTH_MAX = '1;

    // Source head word toward the arbiter
    typedef struct packed {
        logic valid;
        daq_word_t word;
    } src_port_t;

endpackage

/* hw/daq_regs.sv */
module daq_regs #(
    parameter daq_bus_pkg::reg_data_t VERSION_MAJOR = 8'd0,
    parameter daq_bus_pkg::reg_data_t VERSION_MINOR = 8'd0,
    parameter daq_bus_pkg::reg_data_t BOARD_ID = 8'd0
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  daq_bus_pkg::apb_req_t  apb,
    output daq_bus_pkg::reg_data_t prdata,
    output daq_bus_pkg::ctrl_t     ctrl
);

    // Access phase strobes
    logic wr_acc;
    logic rd_acc;

    // Software-set clock configured flag
    logic configured;
    logic [daq_bus_pkg::CTRL_W-1:0] control;
    logic [daq_bus_pkg::PULSE_WIDTH_W-1:0] pulse_width;
    logic pulse_start;

    assign wr_acc = apb.psel & apb.penable & apb.pwrite;
    assign rd_acc = apb.psel & apb.penable & ~apb.pwrite;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            configured <= 1'b0;
            control <= '0;
            pulse_width <= '0;
            pulse_start <= 1'b0;
        end else begin
            // Strobe only for the cycle after the write
            pulse_start <= 1'b0;
            if (wr_acc) begin
                case (apb.paddr)
                    daq_bus_pkg::ADDR_CONFIGURED: begin
                        configured <= apb.pwdata[0];
                    end
                    daq_bus_pkg::ADDR_CONTROL: begin
                        control <= apb.pwdata[daq_bus_pkg::CTRL_W-1:0];
                    end
                    daq_bus_pkg::ADDR_PULSE_WIDTH: begin
                        pulse_width <= apb.pwdata;
                    end
                    // Any value starts the pulse
                    daq_bus_pkg::ADDR_PULSE_START: begin
                        pulse_start <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Zero-latency read mux
    always_comb begin
        prdata = '0;
        if (rd_acc) begin
            case (apb.paddr)
                daq_bus_pkg::ADDR_VERSION: prdata = daq_bus_pkg::MODULE_VERSION;
                daq_bus_pkg::ADDR_VER_MINOR: prdata = VERSION_MINOR;
                daq_bus_pkg::ADDR_VER_MAJOR: prdata = VERSION_MAJOR;
                daq_bus_pkg::ADDR_BOARD: prdata = BOARD_ID;
                daq_bus_pkg::ADDR_CONFIGURED: prdata = {7'd0, configured};
                daq_bus_pkg::ADDR_CONTROL: begin
                    prdata = {{(daq_bus_pkg::REG_W - daq_bus_pkg::CTRL_W){1'b0}}, control};
                end
                daq_bus_pkg::ADDR_PULSE_WIDTH: prdata = pulse_width;
                // Start register is write-only, reads as zero
                default: prdata = '0;
            endcase
        end
    end

    // Fan out to the neighbors
    always_comb begin
        ctrl.trigger_en = control[daq_bus_pkg::CTRL_TRIGGER_EN];
        ctrl.tdc_en = control[daq_bus_pkg::CTRL_TDC_EN];
        ctrl.reset_hold = control[daq_bus_pkg::CTRL_RESET_HOLD];
        ctrl.pulse_width = pulse_width;
        ctrl.pulse_start = pulse_start;
    end

endmodule

/* hw/hitor_tdc.sv */
module hitor_tdc #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic                   hitor,
    input  logic                   tdc_en,
    output daq_data_pkg::src_port_t src,
    input  logic                   grant
);

    logic [1:0] hit_sync;
    logic hit_prev;
    logic hit_rise;
    logic hit_fall;

    // Pulse started while enabled and still valid
    logic armed;
    logic [daq_data_pkg::TDC_LEN_W-1:0] width_cnt;
    logic [daq_data_pkg::TDC_HIT_W-1:0] hit_num;

    logic hit_done;
    logic fifo_wr;
    logic fifo_empty;
    logic fifo_full;
    daq_data_pkg::tdc_word_t wr_word;
    daq_data_pkg::tdc_word_t rd_word;

    assign hit_rise = hit_sync[1] & ~hit_prev;
    assign hit_fall = ~hit_sync[1] & hit_prev;

    // Completed pulse, counted even if the word is dropped
    assign hit_done = hit_fall & armed & tdc_en;
    assign fifo_wr = hit_done & ~fifo_full;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            hit_sync <= '0;
            hit_prev <= 1'b0;
            armed <= 1'b0;
            width_cnt <= '0;
            hit_num <= '0;
        end else begin
            hit_sync <= {hit_sync[0], hitor};
            hit_prev <= hit_sync[1];
            if (hit_rise) begin
                // First high sample counts as one
                armed <= tdc_en;
                width_cnt <= 1;
            end else if (hit_sync[1] && width_cnt != daq_data_pkg::TDC_WIDTH_MAX) begin
                width_cnt <= width_cnt + 1'b1;
            end
            // Disable mid-pulse discards it
            if (!tdc_en) begin
                armed <= 1'b0;
            end
            if (hit_done) begin
                armed <= 1'b0;
                hit_num <= hit_num + 1'b1;
            end
        end
    end

    always_comb begin
        wr_word.id = daq_data_pkg::TDC_ID;
        wr_word.hit = hit_num;
        wr_word.width = width_cnt;
    end

    word_fifo #(
        .payload_t(daq_data_pkg::tdc_word_t),
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .wr_en(fifo_wr),
        .wr_data(wr_word),
        .rd_en(grant),
        .rd_data(rd_word),
        .empty(fifo_empty),
        .full(fifo_full)
    );

    assign src.valid = ~fifo_empty;
    assign src.word = daq_data_pkg::daq_word_t'(rd_word);

endmodule

/* hw/reset_pulser.sv */
module reset_pulser (
    input  logic                                  BUS_CLK,
    input  logic                                  BUS_RST,
    input  logic                                  pulse_start,
    input  logic [daq_bus_pkg::PULSE_WIDTH_W-1:0] pulse_width,
    input  logic                                  reset_hold,
    output logic                                  chip_reset_n
);

    // Remaining pulse cycles
    logic [daq_bus_pkg::PULSE_WIDTH_W-1:0] remain;
    logic pulse;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            remain <= '0;
        end else if (pulse_start) begin
            // Restart, also when a pulse is running
            remain <= pulse_width;
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // Pulse lasts exactly pulse_width cycles, none for zero
    assign pulse = (remain != '0);

    // Active low toward the chip
    // hold bit overrides the timed pulse
    assign chip_reset_n = ~(pulse | reset_hold);

endmodule

/* hw/rr_arbiter.sv */
module rr_arbiter (
    input  logic                    BUS_CLK,
    input  logic                    BUS_RST,
    input  daq_data_pkg::src_port_t trig_src,
    input  daq_data_pkg::src_port_t tdc_src,
    output logic                    trig_grant,
    output logic                    tdc_grant,
    output daq_data_pkg::daq_word_t out_word,
    output logic                    out_write,
    input  logic                    out_ready
);

    // Set when the TDC source was served last
    logic last_tdc;

    // Output register free now or emptying this cycle
    logic can_load;
    logic pick_trig;
    logic pick_tdc;

    assign can_load = ~out_write | out_ready;

    // TDC wins a tie only when the trigger source was served last
    assign pick_tdc = tdc_src.valid & (~trig_src.valid | ~last_tdc);
    assign pick_trig = trig_src.valid & ~pick_tdc;

    assign trig_grant = can_load & pick_trig;
    assign tdc_grant = can_load & pick_tdc;

    // Control state
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            out_write <= 1'b0;
            last_tdc <= 1'b0;
        end else begin
            if (trig_grant | tdc_grant) begin
                out_write <= 1'b1;
                last_tdc <= tdc_grant;
            end else if (out_ready) begin
                // Word left, nothing new
                out_write <= 1'b0;
            end
        end
    end

    // Output word, held until out_ready
    always_ff @(posedge BUS_CLK) begin
        if (tdc_grant) begin
            out_word <= tdc_src.word;
        end else if (trig_grant) begin
            out_word <= trig_src.word;
        end
    end

endmodule

/* hw/trigger_recorder.sv */
module trigger_recorder #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic                   trigger,
    input  logic                   trigger_en,
    output daq_data_pkg::src_port_t src,
    input  logic                   grant,
    output logic                   trigger_busy
);

    // Two-flop synchronizer plus edge history
    logic [1:0] trig_sync;
    logic trig_prev;
    logic trig_rise;

    // Next trigger number
    logic [daq_data_pkg::WORD_W-2:0] trig_num;

    logic accept;
    logic fifo_empty;
    logic fifo_full;
    daq_data_pkg::trigger_word_t wr_word;
    daq_data_pkg::trigger_word_t rd_word;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            trig_sync <= '0;
            trig_prev <= 1'b0;
            trig_num <= '0;
        end else begin
            trig_sync <= {trig_sync[0], trigger};
            trig_prev <= trig_sync[1];
            if (accept) begin
                trig_num <= trig_num + 1'b1;
            end
        end
    end

    assign trig_rise = trig_sync[1] & ~trig_prev;

    // Edges while disabled or full are lost
    assign accept = trig_rise & trigger_en & ~fifo_full;

    always_comb begin
        wr_word.flag = 1'b1;
        wr_word.number = trig_num;
    end

    word_fifo #(
        .payload_t(daq_data_pkg::trigger_word_t),
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .wr_en(accept),
        .wr_data(wr_word),
        .rd_en(grant),
        .rd_data(rd_word),
        .empty(fifo_empty),
        .full(fifo_full)
    );

    assign src.valid = ~fifo_empty;
    assign src.word = daq_data_pkg::daq_word_t'(rd_word);
    assign trigger_busy = fifo_full;

endmodule

/* hw/word_fifo.sv */
module word_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 8
) (
    input  logic     BUS_CLK,
    input  logic     BUS_RST,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Qualified strobes
    logic do_wr;
    logic do_rd;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // Show-ahead read port
    assign rd_data = mem[rd_ptr];

    // Storage, no reset
    always_ff @(posedge BUS_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write keeps the count
            if (do_wr & ~do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd & ~do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the daq_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module daq_core_tb -o daq_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/daq_core_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

/* verif/daq_core_asserts.sv */
module daq_core_asserts #(
    parameter daq_bus_pkg::reg_data_t VERSION_MAJOR = 8'd0,
    parameter daq_bus_pkg::reg_data_t VERSION_MINOR = 8'd0,
    parameter daq_bus_pkg::reg_data_t BOARD_ID = 8'd0
) (
    input logic                    BUS_CLK,
    input logic                    BUS_RST,
    input daq_bus_pkg::apb_req_t   apb,
    input daq_bus_pkg::reg_data_t  prdata,
    input logic                    hitor,
    input daq_data_pkg::daq_word_t out_word,
    input logic                    out_write,
    input logic                    out_ready,
    input logic                    chip_reset_n
);

    // Failures so far, read by the testbench
    int fail_count = 0;

    // Bus and port events
    logic wr_acc;
    logic rd_acc;
    logic xfer;
    logic trig_xfer;
    logic tdc_xfer;

    // Register model
    logic cfg_q;
    logic [2:0] ctrl_q;
    logic [7:0] width_q;
    daq_bus_pkg::reg_data_t exp_rd;

    // Cycles since the start write, saturates at all ones
    logic [8:0] since;
    logic [7:0] run_w;
    logic pulse_exp;

    // Reset seen at the previous edge
    logic rst_d = 1'b0;
    logic [30:0] exp_trig;
    logic [11:0] exp_hit;

    // High lengths measured at the hitor pin
    logic [15:0] hi_len;
    logic hi_ok;
    logic [15:0] widths [64];
    logic [5:0] wr_i;
    logic [5:0] rd_i;
    logic [15:0] exp_width;
    logic width_pending;

    assign wr_acc = apb.psel & apb.penable & apb.pwrite;
    assign rd_acc = apb.psel & apb.penable & ~apb.pwrite;
    assign xfer = out_write & out_ready;
    assign trig_xfer = xfer & out_word[31];
    assign tdc_xfer = xfer & (out_word[31:28] == daq_data_pkg::TDC_ID);

    // Low from two cycles after the start edge, W cycles long
    assign pulse_exp = (since >= 9'd2) && (since <= {1'b0, run_w} + 9'd1);

    assign exp_width = widths[rd_i];
    assign width_pending = (wr_i != rd_i);

    always_comb begin
        case (apb.paddr)
            daq_bus_pkg::ADDR_VERSION: exp_rd = 8'd1;
            daq_bus_pkg::ADDR_VER_MINOR: exp_rd = VERSION_MINOR;
            daq_bus_pkg::ADDR_VER_MAJOR: exp_rd = VERSION_MAJOR;
            daq_bus_pkg::ADDR_BOARD: exp_rd = BOARD_ID;
            daq_bus_pkg::ADDR_CONFIGURED: exp_rd = {7'd0, cfg_q};
            daq_bus_pkg::ADDR_CONTROL: exp_rd = {5'd0, ctrl_q};
            daq_bus_pkg::ADDR_PULSE_WIDTH: exp_rd = width_q;
            // Unmapped reads as zero
            default: exp_rd = 8'd0;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        rst_d <= BUS_RST;
        if (BUS_RST) begin
            cfg_q <= 1'b0;
            ctrl_q <= '0;
            width_q <= '0;
            run_w <= '0;
            since <= '1;
            exp_trig <= '0;
            exp_hit <= '0;
            hi_len <= '0;
            hi_ok <= 1'b0;
            wr_i <= '0;
            rd_i <= '0;
        end else begin
            if (wr_acc && apb.paddr == daq_bus_pkg::ADDR_CONFIGURED) begin
                cfg_q <= apb.pwdata[0];
            end
            if (wr_acc && apb.paddr == daq_bus_pkg::ADDR_CONTROL) begin
                ctrl_q <= apb.pwdata[2:0];
            end
            if (wr_acc && apb.paddr == daq_bus_pkg::ADDR_PULSE_WIDTH) begin
                width_q <= apb.pwdata;
            end
            if (wr_acc && apb.paddr == daq_bus_pkg::ADDR_PULSE_START) begin
                since <= 9'd1;
                run_w <= width_q;
            end else if (since != '1) begin
                since <= since + 9'd1;
            end
            if (trig_xfer) begin
                exp_trig <= exp_trig + 31'd1;
            end
            if (tdc_xfer) begin
                exp_hit <= exp_hit + 12'd1;
                rd_i <= rd_i + 6'd1;
            end
            // Pulse counts only if the TDC stayed enabled throughout
            if (hitor) begin
                if (hi_len == '0) begin
                    hi_ok <= ctrl_q[1];
                end else if (!ctrl_q[1]) begin
                    hi_ok <= 1'b0;
                end
                if (hi_len != daq_data_pkg::TDC_WIDTH_MAX) begin
                    hi_len <= hi_len + 16'd1;
                end
            end else if (hi_len != '0) begin
                if (hi_ok && ctrl_q[1]) begin
                    widths[wr_i] <= hi_len;
                    wr_i <= wr_i + 6'd1;
                end
                hi_len <= '0;
            end
        end
    end

    a_read: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        rd_acc |-> prdata == exp_rd)
    else begin
        fail_count++;
        $error("prdata %0h differs from expected %0h", prdata, exp_rd);
    end

    a_chip_reset: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        chip_reset_n == ~(pulse_exp | ctrl_q[2]))
    else begin
        fail_count++;
        $error("chip_reset_n is %0b, pulse %0b hold %0b", chip_reset_n, pulse_exp, ctrl_q[2]);
    end

    a_trig_number: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        trig_xfer |-> out_word[30:0] == exp_trig)
    else begin
        fail_count++;
        $error("trigger number %0d, expected %0d", out_word[30:0], exp_trig);
    end

    a_tdc_width: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        tdc_xfer |-> width_pending && out_word[15:0] == exp_width)
    else begin
        fail_count++;
        $error("TDC width %0d, expected %0d", out_word[15:0], exp_width);
    end

    a_tdc_hit: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        tdc_xfer |-> out_word[27:16] == exp_hit)
    else begin
        fail_count++;
        $error("TDC hit number %0d, expected %0d", out_word[27:16], exp_hit);
    end

    a_word_hold: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        out_write && !out_ready |=> out_write && $stable(out_word))
    else begin
        fail_count++;
        $error("out_word or out_write changed under back-pressure");
    end

    a_reset_quiet: assert property (@(posedge BUS_CLK)
        rst_d && BUS_RST |-> !out_write)
    else begin
        fail_count++;
        $error("out_write high during reset");
    end

endmodule

bind daq_core daq_core_asserts #(
    .VERSION_MAJOR(VERSION_MAJOR),
    .VERSION_MINOR(VERSION_MINOR),
    .BOARD_ID(BOARD_ID)
) u_asserts (
    .BUS_CLK(BUS_CLK),
    .BUS_RST(BUS_RST),
    .apb(apb),
    .prdata(prdata),
    .hitor(hitor),
    .out_word(out_word),
    .out_write(out_write),
    .out_ready(out_ready),
    .chip_reset_n(chip_reset_n)
);

/* verif/daq_core_tb.sv */
module daq_core_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int NUM_TESTS = 5;
    // Cycle budget per test at several times the longest one
    localparam int TEST_CYCLES = 2500;
    localparam int DRAIN_CYCLES = 500;
    localparam daq_bus_pkg::reg_data_t VER_MAJOR = 8'd3;
    localparam daq_bus_pkg::reg_data_t VER_MINOR = 8'd7;
    localparam daq_bus_pkg::reg_data_t BOARD = 8'd5;

    logic BUS_CLK;
    logic BUS_RST;
    daq_bus_pkg::apb_req_t apb;
    daq_bus_pkg::reg_data_t prdata;
    logic trigger;
    logic hitor;
    daq_data_pkg::daq_word_t out_word;
    logic out_write;
    logic out_ready;
    logic trigger_busy;
    logic chip_reset_n;

    int seed;
    logic hold_ready_low;
    int errors;
    int err_mark;
    int asrt_mark;
    int tests_run;
    int tests_failed;
    // Words seen leaving the output port
    int trig_words;
    int tdc_words;

    daq_core #(
        .VERSION_MAJOR(VER_MAJOR),
        .VERSION_MINOR(VER_MINOR),
        .BOARD_ID(BOARD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_dut (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .apb(apb),
        .prdata(prdata),
        .trigger(trigger),
        .hitor(hitor),
        .out_word(out_word),
        .out_write(out_write),
        .out_ready(out_ready),
        .trigger_busy(trigger_busy),
        .chip_reset_n(chip_reset_n)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    // Random back-pressure with ready three cycles in four
    always @(negedge BUS_CLK) begin
        if (BUS_RST || hold_ready_low) begin
            out_ready = 1'b0;
        end else begin
            out_ready = (($random(seed) & 3) != 0);
        end
    end

    always @(posedge BUS_CLK) begin
        if (!BUS_RST && out_write && out_ready) begin
            if (out_word[31]) begin
                trig_words++;
            end else if (out_word[31:28] == daq_data_pkg::TDC_ID) begin
                tdc_words++;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * TEST_CYCLES));
        $display("Watchdog expired, the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge BUS_CLK);
    endtask

    // Setup phase, access phase, then idle bus
    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input daq_bus_pkg::reg_data_t data);
        @(negedge BUS_CLK);
        apb.psel = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite = write;
        apb.paddr = addr;
        apb.pwdata = data;
        @(negedge BUS_CLK);
        apb.penable = 1'b1;
        @(negedge BUS_CLK);
        apb.psel = 1'b0;
        apb.penable = 1'b0;
        apb.pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input daq_bus_pkg::reg_data_t data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [31:0] addr);
        apb_access(1'b0, addr, 8'h00);
    endtask

    task automatic pulse_trigger(input int high, input int low);
        trigger = 1'b1;
        idle(high);
        trigger = 1'b0;
        idle(low);
    endtask

    task automatic pulse_hitor(input int high, input int low);
        hitor = 1'b1;
        idle(high);
        hitor = 1'b0;
        idle(low);
    endtask

    // Drained once out_write stays low two cycles
    task automatic wait_drained();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        idle(4);
        while (quiet < 2 && waited < DRAIN_CYCLES) begin
            @(negedge BUS_CLK);
            quiet = out_write ? 0 : quiet + 1;
            waited++;
        end
        if (quiet < 2) begin
            $display("Output port did not drain within %0d cycles at %0t", DRAIN_CYCLES, $time);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int want);
        assert (got == want) else begin
            $display("FAILED at %0t: %s words %0d, expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int new_fails;
        new_fails = (u_dut.u_asserts.fail_count - asrt_mark) + (errors - err_mark);
        tests_run++;
        if (new_fails == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("FAILED at %0t: test %s, %0d failed checks", $time, name, new_fails);
        end
        asrt_mark = u_dut.u_asserts.fail_count;
        err_mark = errors;
    endtask

    initial begin
        int base_trig;
        int base_tdc;
        int sent;
        int w;
        seed = 32'h34381d44;
        apb = '0;
        trigger = 1'b0;
        hitor = 1'b0;
        out_ready = 1'b0;
        hold_ready_low = 1'b0;
        errors = 0;
        err_mark = 0;
        asrt_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        trig_words = 0;
        tdc_words = 0;
        BUS_RST = 1'b1;
        idle(RESET_CYCLES);
        BUS_RST = 1'b0;
        idle(2);

        // Identity registers, configured flag, one unmapped address
        apb_read(daq_bus_pkg::ADDR_VERSION);
        apb_read(daq_bus_pkg::ADDR_VER_MINOR);
        apb_read(daq_bus_pkg::ADDR_VER_MAJOR);
        apb_read(daq_bus_pkg::ADDR_BOARD);
        apb_write(daq_bus_pkg::ADDR_CONFIGURED, 8'h01);
        apb_read(daq_bus_pkg::ADDR_CONFIGURED);
        apb_write(daq_bus_pkg::ADDR_CONFIGURED, 8'hfe);
        apb_read(daq_bus_pkg::ADDR_CONFIGURED);
        apb_read(32'd8);
        finish_test("registers");

        // Random widths, then zero width, then the hold bit
        for (int i = 0; i < 4; i++) begin
            w = (i == 3) ? 0 : rand_range(1, 20);
            apb_write(daq_bus_pkg::ADDR_PULSE_WIDTH, 8'(w));
            apb_read(daq_bus_pkg::ADDR_PULSE_WIDTH);
            apb_write(daq_bus_pkg::ADDR_PULSE_START, 8'h00);
            idle(w + 6);
        end
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h04);
        idle(5);
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h00);
        idle(5);
        finish_test("chip reset pulser");

        // Free flow first, then the output port blocked
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h01);
        base_trig = trig_words;
        for (int i = 0; i < 10; i++) begin
            pulse_trigger(3, rand_range(3, 8));
        end
        wait_drained();
        check_count("trigger", trig_words - base_trig, 10);
        hold_ready_low = 1'b1;
        base_trig = trig_words;
        sent = 0;
        while (!trigger_busy && sent < 3 * FIFO_DEPTH) begin
            pulse_trigger(3, 4);
            sent++;
        end
        if (!trigger_busy) begin
            $display("trigger_busy did not rise after %0d triggers", sent);
            errors++;
        end
        // One word waits in the output register while the FIFO fills
        assert (sent == FIFO_DEPTH + 1) else begin
            $display("FAILED at %0t: trigger_busy rose after %0d triggers, expected %0d",
                     $time, sent, FIFO_DEPTH + 1);
            errors++;
        end
        // These must be lost
        for (int i = 0; i < 4; i++) begin
            pulse_trigger(3, 4);
            assert (trigger_busy) else begin
                $display("FAILED at %0t: trigger_busy dropped with out_ready low", $time);
                errors++;
            end
        end
        hold_ready_low = 1'b0;
        wait_drained();
        check_count("trigger", trig_words - base_trig, sent);
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h00);
        finish_test("trigger recorder");

        // TDC pulses with one cut short by disabling the TDC
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h02);
        base_tdc = tdc_words;
        for (int i = 0; i < 12; i++) begin
            pulse_hitor(rand_range(1, 30), rand_range(4, 9));
        end
        hitor = 1'b1;
        idle(5);
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h00);
        idle(3);
        hitor = 1'b0;
        idle(6);
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h02);
        idle(4);
        pulse_hitor(7, 5);
        wait_drained();
        check_count("TDC", tdc_words - base_tdc, 13);
        finish_test("hit-or TDC");

        // Both sources through the arbiter
        apb_write(daq_bus_pkg::ADDR_CONTROL, 8'h03);
        base_trig = trig_words;
        base_tdc = tdc_words;
        for (int i = 0; i < 10; i++) begin
            pulse_trigger(rand_range(2, 4), 3);
            pulse_hitor(rand_range(1, 10), 4);
        end
        wait_drained();
        check_count("trigger", trig_words - base_trig, 10);
        check_count("TDC", tdc_words - base_tdc, 10);
        finish_test("mixed sources");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors + u_dut.u_asserts.fail_count);
        if (tests_failed == 0 && errors == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/daq_bus_pkg.sv
hw/daq_data_pkg.sv
hw/word_fifo.sv
hw/daq_regs.sv
hw/reset_pulser.sv
hw/trigger_recorder.sv
hw/hitor_tdc.sv
hw/rr_arbiter.sv
hw/daq_core.sv
verif/daq_core_asserts.sv
verif/daq_core_tb.sv
